// ==== design/cipher_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and helpers for the cipher round engine.
// Holds the block geometry, the 128-bit state union and
// the GF(2^8) multipliers used by MixColumns.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cipher_pkg;

    localparam int N_BYTES = 16;                    // Bytes per block.
    localparam int N_WORDS = 4;                     // Host words per block.
    localparam int N_ROWS  = 4;                     // Rows of the AES state.

    typedef logic [31:0] word_t;

    // Byte 4c+r is row r, column c; word w holds bytes 4w..4w+3.
    typedef union packed {
        logic [N_BYTES-1:0][7:0] bytes;
        word_t [N_WORDS-1:0]     words;
    } state_t;

    // Multiply by 2 modulo x^8 + x^4 + x^3 + x + 1.
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul3(input logic [7:0] b);
        return xtime(b) ^ b;                        // 3b = 2b + b.
    endfunction

endpackage

`default_nettype wire

// ==== design/round_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One round's operands and result between the round
// controller and the combinational round datapath.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface round_if;

    cipher_pkg::state_t state_in;                   // State entering the round.
    cipher_pkg::state_t round_key;                  // Key for AddRoundKey.
    logic               final_round;                // High to skip MixColumns.
    cipher_pkg::state_t state_out;                  // State after the round.

    modport ctrl (
        output state_in,
        output round_key,
        output final_round,
        input  state_out
    );

    modport unit (
        input  state_in,
        input  round_key,
        input  final_round,
        output state_out
    );

endinterface

`default_nettype wire

// ==== design/state_loader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Collects four 32-bit host words into a 16-byte block.
// Each word_valid stores one word; after the fourth the
// block is published and block_full pulses for one cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module state_loader (
    input  logic               clk,
    input  logic               resetn,
    input  cipher_pkg::word_t  word,
    input  logic               word_valid,
    output cipher_pkg::state_t block,
    output logic               block_full
);

    localparam int IDX_W = $clog2(cipher_pkg::N_WORDS);

    cipher_pkg::state_t work;                       // Block under assembly.
    logic [IDX_W-1:0]   count;                      // Next word slot.
    logic               complete;                   // Fourth word just stored.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            work     <= '0;
            count    <= '0;
            complete <= 1'b0;
        end
        else
        begin
            complete <= 1'b0;
            if (word_valid)
            begin
                work.words[count] <= word;
                count             <= count + 1'b1;  // Wraps after the last slot.
                complete          <= (count == IDX_W'(cipher_pkg::N_WORDS - 1));
            end
        end
    end

    // Publish one cycle after the last word lands in work.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            block      <= '0;
            block_full <= 1'b0;
        end
        else
        begin
            block_full <= complete;
            if (complete)
                block <= work;
        end
    end

    a_full_single: assert property (@(posedge clk) disable iff (!resetn)
        block_full |=> !block_full);

endmodule

`default_nettype wire

// ==== design/round_datapath.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational AES linear layer for one round.
// Applies ShiftRows, MixColumns unless final_round is set,
// then AddRoundKey with the supplied round key.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module round_datapath (
    round_if.unit bus
);

    localparam int N_COLS = cipher_pkg::N_BYTES / cipher_pkg::N_ROWS;

    cipher_pkg::state_t shifted;                    // After ShiftRows.
    cipher_pkg::state_t mixed;                      // After optional MixColumns.

    // Row r moves left by r columns.
    always_comb
    begin
        shifted = '0;
        for (int c = 0; c < N_COLS; c++)
        begin
            for (int r = 0; r < cipher_pkg::N_ROWS; r++)
            begin
                shifted.bytes[cipher_pkg::N_ROWS*c + r] =
                    bus.state_in.bytes[cipher_pkg::N_ROWS*((c + r) % N_COLS) + r];
            end
        end
    end

    // Each output byte is 2*a(r) + 3*a(r+1) + a(r+2) + a(r+3) within its column.
    always_comb
    begin
        mixed = shifted;
        if (!bus.final_round)
        begin
            for (int c = 0; c < N_COLS; c++)
            begin
                for (int r = 0; r < cipher_pkg::N_ROWS; r++)
                begin
                    mixed.bytes[cipher_pkg::N_ROWS*c + r] =
                        cipher_pkg::xtime(
                            shifted.bytes[cipher_pkg::N_ROWS*c + r]) ^
                        cipher_pkg::gf_mul3(
                            shifted.bytes[cipher_pkg::N_ROWS*c + (r + 1) % cipher_pkg::N_ROWS]) ^
                        shifted.bytes[cipher_pkg::N_ROWS*c + (r + 2) % cipher_pkg::N_ROWS] ^
                        shifted.bytes[cipher_pkg::N_ROWS*c + (r + 3) % cipher_pkg::N_ROWS];
                end
            end
        end
    end

    always_comb
    begin
        bus.state_out = mixed ^ bus.round_key;      // AddRoundKey.
    end

endmodule

`default_nettype wire

// ==== design/round_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round sequencer. Captures a data and key block when idle,
// runs ROUNDS single-cycle rounds through the datapath,
// starts the unloader and stays busy until output is done.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module round_ctrl #(
    parameter int ROUNDS = 2
) (
    input  logic               clk,
    input  logic               resetn,
    input  cipher_pkg::state_t data_block,
    input  cipher_pkg::state_t key_block,
    input  logic               data_full,
    round_if.ctrl              bus,
    output cipher_pkg::state_t result,
    output logic               unload_start,
    output logic               busy
);

    localparam int CNT_MAX = (ROUNDS > cipher_pkg::N_WORDS) ? ROUNDS : cipher_pkg::N_WORDS;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ROUND = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    logic [1:0]         state;
    logic [CNT_W-1:0]   cnt;                        // Round index, then drain count.
    cipher_pkg::state_t work_state;
    cipher_pkg::state_t work_key;                   // Held so a late key write is harmless.
    logic               last_round;

    assign last_round      = (cnt == CNT_W'(ROUNDS - 1));
    assign bus.state_in    = work_state;
    assign bus.round_key   = work_key;
    assign bus.final_round = (state == ST_ROUND) && last_round;
    assign result          = work_state;            // Stable through drain.
    assign busy            = (state != ST_IDLE);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state        <= ST_IDLE;
            cnt          <= '0;
            work_state   <= '0;
            work_key     <= '0;
            unload_start <= 1'b0;
        end
        else
        begin
            unload_start <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (data_full)
                    begin
                        work_state <= data_block;
                        work_key   <= key_block;
                        cnt        <= '0;
                        state      <= ST_ROUND;
                    end
                end
                ST_ROUND:
                begin
                    work_state <= bus.state_out;
                    if (last_round)
                    begin
                        cnt          <= '0;
                        unload_start <= 1'b1;
                        state        <= ST_DRAIN;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                ST_DRAIN:
                begin
                    // Covers the start cycle plus four output words.
                    if (cnt == CNT_W'(cipher_pkg::N_WORDS))
                    begin
                        cnt   <= '0;
                        state <= ST_IDLE;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Start comes from the round state after exactly ROUNDS round cycles.
    a_start_from_round: assert property (@(posedge clk) disable iff (!resetn)
        unload_start |-> $past(state) == ST_ROUND && $past(state, ROUNDS + 1) == ST_IDLE);

endmodule

`default_nettype wire

// ==== design/state_unloader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Returns a 16-byte result to the host as four 32-bit
// words on consecutive cycles, word 0 first.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module state_unloader (
    input  logic               clk,
    input  logic               resetn,
    input  cipher_pkg::state_t result,
    input  logic               start,
    output cipher_pkg::word_t  out_word,
    output logic               out_valid
);

    localparam int IDX_W = $clog2(cipher_pkg::N_WORDS);

    cipher_pkg::state_t hold;                       // Latched result.
    logic [IDX_W-1:0]   idx;                        // Word being presented.
    logic               active;

    assign out_word  = hold.words[idx];
    assign out_valid = active;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            hold   <= '0;
            idx    <= '0;
            active <= 1'b0;
        end
        else if (start)
        begin
            hold   <= result;
            idx    <= '0;
            active <= 1'b1;
        end
        else if (active)
        begin
            idx <= idx + 1'b1;
            if (idx == IDX_W'(cipher_pkg::N_WORDS - 1))
                active <= 1'b0;                     // Last word leaves this cycle.
        end
    end

    // The controller must not restart a transfer in progress.
    a_no_restart: assert property (@(posedge clk) disable iff (!resetn)
        start |-> !active);

endmodule

`default_nettype wire

// ==== design/cipher_round_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the cipher round engine.
// Host writes data and key words together on data_valid;
// results return on out_word/out_valid, busy blocks new input.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cipher_round_top #(
    parameter int ROUNDS = 2
) (
    input  logic              clk,
    input  logic              resetn,
    input  cipher_pkg::word_t data_word,
    input  cipher_pkg::word_t key_word,
    input  logic              data_valid,
    output cipher_pkg::word_t out_word,
    output logic              out_valid,
    output logic              busy
);

    cipher_pkg::state_t data_block;
    cipher_pkg::state_t key_block;
    cipher_pkg::state_t result;
    logic               data_full;
    logic               unload_start;

    round_if u_round_if ();

    state_loader u_data_loader (
        .clk        (clk),
        .resetn     (resetn),
        .word       (data_word),
        .word_valid (data_valid),
        .block      (data_block),
        .block_full (data_full)
    );

    // Fills in step with the data loader, so its full pulse is not needed.
    state_loader u_key_loader (
        .clk        (clk),
        .resetn     (resetn),
        .word       (key_word),
        .word_valid (data_valid),
        .block      (key_block),
        .block_full ()
    );

    round_datapath u_round_datapath (
        .bus (u_round_if.unit)
    );

    round_ctrl #(
        .ROUNDS (ROUNDS)
    ) u_round_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .data_block   (data_block),
        .key_block    (key_block),
        .data_full    (data_full),
        .bus          (u_round_if.ctrl),
        .result       (result),
        .unload_start (unload_start),
        .busy         (busy)
    );

    state_unloader u_state_unloader (
        .clk       (clk),
        .resetn    (resetn),
        .result    (result),
        .start     (unload_start),
        .out_word  (out_word),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== verification/tb_cipher_round.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the cipher round engine.
// Sends data and key blocks, collects the four result words
// and compares them with a behavioral AES linear-layer model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_cipher_round;

    localparam int ROUNDS  = 2;
    localparam int TIMEOUT = 100;                   // Cycles allowed for any wait.

    logic        clk;
    logic        resetn;
    logic [31:0] data_word;
    logic [31:0] key_word;
    logic        data_valid;
    logic [31:0] out_word;
    logic        out_valid;
    logic        busy;
    integer      seed;
    int          errors;

    cipher_round_top #(
        .ROUNDS (ROUNDS)
    ) u_cipher_round_top (
        .clk        (clk),
        .resetn     (resetn),
        .data_word  (data_word),
        .key_word   (key_word),
        .data_valid (data_valid),
        .out_word   (out_word),
        .out_valid  (out_valid),
        .busy       (busy)
    );

    always #20 clk = ~clk;

    task automatic stop_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
            stop_run("value mismatch");
        end
    endtask

    // Inputs change and outputs are read 5 units after each rising edge.
    task automatic step();
        @(posedge clk);
        #5;
    endtask

    function automatic logic [7:0] gf_double(input logic [7:0] b);
        logic [7:0] sh;
        sh = {b[6:0], 1'b0};
        return b[7] ? (sh ^ 8'h1b) : sh;            // Reduce by the AES polynomial.
    endfunction

    function automatic logic [7:0] gf_triple(input logic [7:0] b);
        return gf_double(b) ^ b;
    endfunction

    function automatic logic [127:0] model_round(input logic [127:0] s, input logic [127:0] k,
                                                 input bit last);
        logic [127:0] sr;
        logic [127:0] mc;
        logic [7:0]   a0, a1, a2, a3;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                sr[8*(4*c+r) +: 8] = s[8*(4*((c+r)%4)+r) +: 8];   // Row r rotates left by r.
        mc = sr;
        if (!last)
        begin
            for (int c = 0; c < 4; c++)
            begin
                a0 = sr[8*(4*c)   +: 8];
                a1 = sr[8*(4*c+1) +: 8];
                a2 = sr[8*(4*c+2) +: 8];
                a3 = sr[8*(4*c+3) +: 8];
                mc[8*(4*c)   +: 8] = gf_double(a0) ^ gf_triple(a1) ^ a2 ^ a3;
                mc[8*(4*c+1) +: 8] = a0 ^ gf_double(a1) ^ gf_triple(a2) ^ a3;
                mc[8*(4*c+2) +: 8] = a0 ^ a1 ^ gf_double(a2) ^ gf_triple(a3);
                mc[8*(4*c+3) +: 8] = gf_triple(a0) ^ a1 ^ a2 ^ gf_double(a3);
            end
        end
        return mc ^ k;                              // AddRoundKey.
    endfunction

    function automatic logic [127:0] model_encrypt(input logic [127:0] data,
                                                   input logic [127:0] key);
        logic [127:0] s;
        s = data;
        for (int i = 0; i < ROUNDS; i++)
            s = model_round(s, key, i == ROUNDS - 1);
        return s;
    endfunction

    task automatic random_block(output logic [127:0] b);
        for (int i = 0; i < 4; i++)
            b[32*i +: 32] = $random(seed);
    endtask

    // Returns just after the edge that samples the fourth word.
    task automatic send_block(input logic [127:0] data, input logic [127:0] key);
        for (int w = 0; w < 4; w++)
        begin
            data_word  = data[32*w +: 32];
            key_word   = key[32*w +: 32];
            data_valid = 1'b1;
            step();
        end
        data_valid = 1'b0;
    endtask

    task automatic wait_for_busy();
        int n;
        n = 0;
        while (!busy)
        begin
            step();
            n++;
            if (n > TIMEOUT)
                stop_run("busy never rose after a block was sent");
        end
    endtask

    task automatic collect_block(output logic [127:0] got);
        int n;
        n = 0;
        while (!out_valid)
        begin
            step();
            n++;
            if (n > TIMEOUT)
                stop_run("out_valid never rose");
        end
        for (int i = 0; i < 4; i++)
        begin
            check_value("out_valid", 1, out_valid);
            check_value("busy", 1, busy);
            got[32*i +: 32] = out_word;
            step();
        end
        check_value("out_valid", 0, out_valid);     // Exactly four words.
        check_value("busy", 0, busy);               // Falls with the last word.
    endtask

    task automatic run_block(input logic [127:0] data, input logic [127:0] key,
                             input logic [127:0] expected);
        logic [127:0] got;
        send_block(data, key);
        collect_block(got);
        check_value("result", expected, got);
    endtask

    task automatic test_idle_after_reset();
        for (int i = 0; i < 20; i++)
        begin
            check_value("out_valid", 0, out_valid);
            check_value("busy", 0, busy);
            step();
        end
    endtask

    task automatic test_known_columns();
        run_block('0, '0, '0);
        // Uniform rows make ShiftRows a no-op, so every column mixes once.
        run_block({4{32'h455313db}}, '0, {4{32'hbca14d8e}});
    endtask

    task automatic test_known_key();
        logic [127:0] data;
        logic [127:0] key;
        data = {32'h340737e0, 32'ha2983131, 32'h8d305a88, 32'ha8f64332};
        key  = {32'h3c4fcf09, 32'h8815f7ab, 32'ha6d2ae28, 32'h16157e2b};
        run_block(data, key, model_encrypt(data, key));
    endtask

    task automatic test_random_blocks();
        logic [127:0] data;
        logic [127:0] key;
        for (int i = 0; i < 10; i++)
        begin
            random_block(data);
            random_block(key);
            run_block(data, key, model_encrypt(data, key));
        end
    endtask

    task automatic test_drop_while_busy();
        logic [127:0] data_a;
        logic [127:0] key_a;
        logic [127:0] data_b;
        logic [127:0] key_b;
        logic [127:0] got;
        random_block(data_a);
        random_block(key_a);
        random_block(data_b);
        random_block(key_b);
        send_block(data_a, key_a);
        wait_for_busy();
        fork
            send_block(data_b, key_b);              // Completes during drain.
            collect_block(got);
        join
        check_value("result", model_encrypt(data_a, key_a), got);
        for (int i = 0; i < 20; i++)
        begin
            check_value("out_valid", 0, out_valid); // Second block was lost.
            check_value("busy", 0, busy);
            step();
        end
    endtask

    task automatic test_latency();
        logic [127:0] data;
        logic [127:0] key;
        logic [127:0] got;
        int n;
        random_block(data);
        random_block(key);
        send_block(data, key);
        n = 0;
        while (!out_valid)
        begin
            step();
            n++;
            if (n > TIMEOUT)
                stop_run("out_valid never rose in the latency test");
        end
        check_value("latency", ROUNDS + 3, n);
        collect_block(got);
        check_value("result", model_encrypt(data, key), got);
    endtask

    initial
    begin
        clk        = 1'b0;
        resetn     = 1'b0;
        data_word  = '0;
        key_word   = '0;
        data_valid = 1'b0;
        seed       = 32'haf33_6ffa;
        errors     = 0;
        repeat (16) @(posedge clk);
        #5;
        resetn = 1'b1;
        test_idle_after_reset();
        test_known_columns();
        test_known_key();
        test_random_blocks();
        test_drop_while_busy();
        test_latency();
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/cipher_pkg.sv
design/round_if.sv
design/state_loader.sv
design/round_datapath.sv
design/round_ctrl.sv
design/state_unloader.sv
design/cipher_round_top.sv
verification/tb_cipher_round.sv

// ==== Bender.yml ====
package:
  name: cipher_round

sources:
  - files:
      - design/cipher_pkg.sv
      - design/round_if.sv
      - design/state_loader.sv
      - design/round_datapath.sv
      - design/round_ctrl.sv
      - design/state_unloader.sv
      - design/cipher_round_top.sv
  - target: test
    files:
      - verification/tb_cipher_round.sv
